//--- build.f
rtl/l2e_pkg.sv
rtl/cmd_router.sv
rtl/cfg_slice.sv
rtl/mem_store.sv
rtl/loopback_dev.sv
rtl/resp_merge.sv
rtl/l2e_tile.sv
tb/tb_clk_gen.sv
tb/l2e_tile_chk.sv
tb/l2e_tile_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module l2e_tile_tb -f build.f

# Keep running past assertion errors so the testbench reports the failure itself
out=$(./obj_dir/Vl2e_tile_tb +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx 'NO ERRORS'

//--- tb/l2e_tile_tb.sv
`timescale 1ns/1ps
`default_nettype none

module l2e_tile_tb;

  import l2e_pkg::*;

  localparam int N_DIRECTED = 26;
  localparam int N_RANDOM   = 64;
  localparam int N_TOTAL    = N_DIRECTED + N_RANDOM;
  localparam int MAX_CYCLES = N_TOTAL * 50 + 200;

  logic              clk;
  logic              arst_n;
  msg_s              cmd;
  logic              cmd_v;
  logic              cmd_ready;
  msg_s              resp;
  logic              resp_v;
  logic              resp_ready;
  logic [DATA_W-1:0] tile_id;

  integer            seed = 56139;
  logic [TAG_W-1:0]  next_tag = '0;
  int                resp_count = 0;
  logic [15:0]       pending = '0;
  msg_s              expected [16];

  // Reference state, updated in acceptance order
  logic              model_freeze = 1'b1;
  logic [DATA_W-1:0] model_scratch = '0;
  logic [DATA_W-1:0] model_mem [MEM_DEPTH] = '{default: '0};

  msg_type_e         rand_kind [N_RANDOM];
  logic [ADDR_W-1:0] rand_addr [N_RANDOM];
  logic [DATA_W-1:0] rand_data [N_RANDOM];

  tb_clk_gen clk_gen_i (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  l2e_tile l2e_tile_i (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .cmd_i        (cmd),
    .cmd_v_i      (cmd_v),
    .cmd_ready_o  (cmd_ready),
    .resp_o       (resp),
    .resp_v_o     (resp_v),
    .resp_ready_i (resp_ready),
    .tile_id_i    (tile_id)
  );

  bind l2e_tile l2e_tile_chk l2e_tile_chk_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cmd_i        (cmd_i),
    .cmd_v_i      (cmd_v_i),
    .cmd_ready_i  (cmd_ready_o),
    .dev_cmd_v_i  (dev_cmd_v),
    .resp_i       (resp_o),
    .resp_v_i     (resp_v_o),
    .resp_ready_i (resp_ready_i)
  );

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic predict_response(input msg_s c, output msg_s r);
    logic [ADDR_W-1:0]   a;
    logic [DEV_W-1:0]    dev;
    logic [OFFSET_W-1:0] ofs;
    logic [3:0]          word;
    logic                wr;
    a        = c.header.addr.flat;
    dev      = a[OFFSET_W +: DEV_W];
    ofs      = a[OFFSET_W-1:0];
    word     = a[6:3];
    wr       = (c.header.msg_type == MSG_WRITE);
    r.header = c.header;
    r.data   = '0;
    if (a >= DRAM_BASE || dev == DEV_MEM)
    begin
      // Frozen store drops writes and reads as zero
      if (wr && !model_freeze)
        model_mem[word] = c.data;
      else if (!wr && !model_freeze)
        r.data = model_mem[word];
    end
    else if (dev == DEV_CFG)
    begin
      if (wr && ofs == CFG_FREEZE_OFS)
        model_freeze = c.data[0];
      else if (wr && ofs == CFG_SCRATCH_OFS)
        model_scratch = c.data;
      else if (!wr && ofs == CFG_FREEZE_OFS)
        r.data = {{(DATA_W-1){1'b0}}, model_freeze};
      else if (!wr && ofs == CFG_SCRATCH_OFS)
        r.data = model_scratch;
      else if (!wr && ofs == CFG_ID_OFS)
        r.data = tile_id;
    end
  endtask

  task automatic make_random_cmds();
    int         dev_pick;
    logic [3:0] word;
    logic [3:0] dev;
    for (int i = 0; i < N_RANDOM; i++)
    begin
      dev_pick     = int'($unsigned($random(seed)) % 3);
      word         = 4'($random(seed)) & 4'h7;
      dev          = 4'($random(seed));
      rand_kind[i] = ($random(seed) & 1) ? MSG_WRITE : MSG_READ;
      rand_data[i] = {$random(seed), $random(seed)};
      case (dev_pick)
        0: rand_addr[i] = (($random(seed) & 1) ? DRAM_BASE : 32'h0020_0000)
                          | {25'd0, word, 3'd0};
        1: rand_addr[i] = 32'h0010_0000 | {27'd0, 2'($unsigned($random(seed)) % 4), 3'd0};
        default:
        begin
          if (dev == DEV_CFG || dev == DEV_MEM)
            dev = 4'hf;
          rand_addr[i] = {8'h00, dev, 20'($random(seed))};
        end
      endcase
    end
  endtask

  // Returns on the edge where the command is taken
  task automatic send_cmd(input msg_type_e kind, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data);
    msg_s c;
    c.header.msg_type  = kind;
    c.header.addr.flat = addr;
    c.header.tag       = next_tag;
    c.data             = data;
    next_tag           = next_tag + 1'b1;
    cmd   <= c;
    cmd_v <= 1'b1;
    @(posedge clk);
    while (!cmd_ready)
      @(posedge clk);
  endtask

  initial
  begin
    resp_ready = 1'b1;
    wait (arst_n);
    forever
    begin
      @(posedge clk);
      resp_ready <= ($random(seed) % 4) != 0;
    end
  end

  // Responses are retired before the same edge's new command is recorded
  always @(posedge clk)
  begin
    msg_s got;
    msg_s want;
    if (arst_n && resp_v && resp_ready)
    begin
      got = resp;
      assert (pending[got.header.tag])
      else abort_run($sformatf("Response with tag %0d arrived with no command outstanding",
                               got.header.tag));
      assert (got === expected[got.header.tag])
      else abort_run($sformatf("CHECK FAILED at %0t: tag %0d response %h, expected %h",
                               $time, got.header.tag, got, expected[got.header.tag]));
      pending[got.header.tag] = 1'b0;
      resp_count++;
    end
    if (arst_n && cmd_v && cmd_ready)
    begin
      assert (!pending[cmd.header.tag])
      else abort_run("A command tag was reused while its response was still outstanding");
      predict_response(cmd, want);
      expected[cmd.header.tag] = want;
      pending[cmd.header.tag]  = 1'b1;
    end
  end

  always @(negedge clk)
  begin
    if (l2e_tile_i.l2e_tile_chk_i.any_failed)
      abort_run("A protocol assertion in the bound checker failed");
  end

  initial
  begin
    repeat (MAX_CYCLES) @(posedge clk);
    abort_run($sformatf("Run timed out after %0d cycles", MAX_CYCLES));
  end

  initial
  begin
    cmd     = '0;
    cmd_v   = 1'b0;
    tile_id = 64'h0000_7e11_0000_0042;
    make_random_cmds();
    wait (arst_n);
    @(posedge clk);
    // Idle tile is ready and silent out of reset
    assert (cmd_ready && !resp_v)
    else abort_run($sformatf("CHECK FAILED at %0t: tile not idle after reset", $time));
    // Frozen after reset
    send_cmd(MSG_READ,  32'h0010_0000, '0);
    send_cmd(MSG_WRITE, 32'h8000_0008, 64'h1111_2222_3333_4444);
    send_cmd(MSG_READ,  32'h8000_0008, '0);
    send_cmd(MSG_READ,  32'h0020_0008, '0);
    // Unfreeze, then flat and local memory accesses
    send_cmd(MSG_WRITE, 32'h0010_0000, 64'h0);
    send_cmd(MSG_READ,  32'h8000_0008, '0);
    send_cmd(MSG_WRITE, 32'h8000_0000, 64'h0123_4567_89ab_cdef);
    send_cmd(MSG_WRITE, 32'h0020_0018, 64'hfeed_face_cafe_beef);
    send_cmd(MSG_WRITE, 32'h8000_0048, 64'h5a5a_a5a5_0f0f_f0f0);
    send_cmd(MSG_READ,  32'h8000_0000, '0);
    send_cmd(MSG_READ,  32'h0020_0018, '0);
    send_cmd(MSG_READ,  32'h8000_0048, '0);
    send_cmd(MSG_READ,  32'h0020_0000, '0);
    // Config registers
    send_cmd(MSG_WRITE, 32'h0010_0008, 64'h0bad_c0de_1234_5678);
    send_cmd(MSG_READ,  32'h0010_0008, '0);
    send_cmd(MSG_READ,  32'h0010_0010, '0);
    send_cmd(MSG_READ,  32'h0010_0018, '0);
    send_cmd(MSG_READ,  32'h0010_0004, '0);
    send_cmd(MSG_READ,  32'h0010_0000, '0);
    // Refrozen store hides a word that holds data
    send_cmd(MSG_WRITE, 32'h0010_0000, 64'h1);
    send_cmd(MSG_READ,  32'h8000_0000, '0);
    send_cmd(MSG_WRITE, 32'h0010_0000, 64'h0);
    // Unmapped local devices
    send_cmd(MSG_READ,  32'h0030_0040, '0);
    send_cmd(MSG_WRITE, 32'h0000_1234, 64'hffff_ffff_ffff_ffff);
    send_cmd(MSG_READ,  32'h00f0_0008, '0);
    send_cmd(MSG_WRITE, 32'h7ff0_0000, 64'h1);
    for (int i = 0; i < N_RANDOM; i++)
      send_cmd(rand_kind[i], rand_addr[i], rand_data[i]);
    cmd_v <= 1'b0;
    wait (resp_count == N_TOTAL);
    @(negedge clk);
    if (pending == '0 && !l2e_tile_i.l2e_tile_chk_i.any_failed)
    begin
      $display("NO ERRORS");
      $finish;
    end
    else
      abort_run("Commands were left without a response at the end of the run");
  end

endmodule

`default_nettype wire

//--- tb/l2e_tile_chk.sv
`timescale 1ns/1ps
`default_nettype none

module l2e_tile_chk (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  l2e_pkg::msg_s                   cmd_i,
  input  logic                            cmd_v_i,
  input  logic                            cmd_ready_i,
  input  logic [l2e_pkg::NUM_DEV-1:0]     dev_cmd_v_i,
  input  l2e_pkg::msg_s                   resp_i,
  input  logic                            resp_v_i,
  input  logic                            resp_ready_i
);

  logic [3:0] inflight_q;
  logic       reset_fail  = 1'b0;
  logic       stall_fail  = 1'b0;
  logic       hold_fail   = 1'b0;
  logic       orphan_fail = 1'b0;
  logic       any_failed;

  // Commands accepted but not yet answered
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      inflight_q <= '0;
    else
      inflight_q <= inflight_q + 4'(cmd_v_i && cmd_ready_i) - 4'(resp_v_i && resp_ready_i);
  end

  assert property (@(posedge clk_i) !arst_n_i |-> !resp_v_i)
  else
  begin
    reset_fail = 1'b1;
    $error("resp_v_o high while reset is asserted");
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_v_i && !resp_ready_i |=> resp_v_i && $stable(resp_i))
  else
  begin
    stall_fail = 1'b1;
    $error("stalled response changed or dropped its valid");
  end

  // Held command must keep pointing at the same device
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_v_i && !cmd_ready_i |=> cmd_v_i && $stable(cmd_i) && $stable(dev_cmd_v_i))
  else
  begin
    hold_fail = 1'b1;
    $error("held command moved or changed its target device");
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_v_i |-> inflight_q != '0)
  else
  begin
    orphan_fail = 1'b1;
    $error("response valid with no command outstanding");
  end

  assign any_failed = reset_fail | stall_fail | hold_fail | orphan_fail;

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int HALF_PERIOD_NS = 20;
  localparam int RESET_CYCLES   = 3;

  initial
  begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // Release on a rising edge, after the flops have seen reset
  initial
  begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

//--- rtl/l2e_tile.sv
`timescale 1ns/1ps
`default_nettype none

module l2e_tile (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  l2e_pkg::msg_s               cmd_i,
  input  logic                        cmd_v_i,
  output logic                        cmd_ready_o,
  output l2e_pkg::msg_s               resp_o,
  output logic                        resp_v_o,
  input  logic                        resp_ready_i,
  input  logic [l2e_pkg::DATA_W-1:0]  tile_id_i
);

  import l2e_pkg::*;

  msg_s                dev_cmd;
  logic [NUM_DEV-1:0]  dev_cmd_v;
  logic [NUM_DEV-1:0]  dev_cmd_ready;
  msg_s [NUM_DEV-1:0]  dev_resp;
  logic [NUM_DEV-1:0]  dev_resp_v;
  logic [NUM_DEV-1:0]  dev_resp_ready;
  logic                freeze;

  cmd_router router_i (
    .cmd_i       (cmd_i),
    .cmd_v_i     (cmd_v_i),
    .cmd_ready_o (cmd_ready_o),
    .dev_cmd_o   (dev_cmd),
    .dev_v_o     (dev_cmd_v),
    .dev_ready_i (dev_cmd_ready)
  );

  mem_store mem_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cmd_i        (dev_cmd),
    .cmd_v_i      (dev_cmd_v[DEV_IDX_MEM]),
    .cmd_ready_o  (dev_cmd_ready[DEV_IDX_MEM]),
    .resp_o       (dev_resp[DEV_IDX_MEM]),
    .resp_v_o     (dev_resp_v[DEV_IDX_MEM]),
    .resp_ready_i (dev_resp_ready[DEV_IDX_MEM]),
    .freeze_i     (freeze)
  );

  cfg_slice cfg_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cmd_i        (dev_cmd),
    .cmd_v_i      (dev_cmd_v[DEV_IDX_CFG]),
    .cmd_ready_o  (dev_cmd_ready[DEV_IDX_CFG]),
    .resp_o       (dev_resp[DEV_IDX_CFG]),
    .resp_v_o     (dev_resp_v[DEV_IDX_CFG]),
    .resp_ready_i (dev_resp_ready[DEV_IDX_CFG]),
    .tile_id_i    (tile_id_i),
    .freeze_o     (freeze)
  );

  loopback_dev loop_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cmd_i        (dev_cmd),
    .cmd_v_i      (dev_cmd_v[DEV_IDX_LOOP]),
    .cmd_ready_o  (dev_cmd_ready[DEV_IDX_LOOP]),
    .resp_o       (dev_resp[DEV_IDX_LOOP]),
    .resp_v_o     (dev_resp_v[DEV_IDX_LOOP]),
    .resp_ready_i (dev_resp_ready[DEV_IDX_LOOP])
  );

  resp_merge merge_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .dev_resp_i   (dev_resp),
    .dev_v_i      (dev_resp_v),
    .dev_ready_o  (dev_resp_ready),
    .resp_o       (resp_o),
    .resp_v_o     (resp_v_o),
    .resp_ready_i (resp_ready_i)
  );

endmodule

`default_nettype wire

//--- rtl/resp_merge.sv
`timescale 1ns/1ps
`default_nettype none

module resp_merge (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  l2e_pkg::msg_s [l2e_pkg::NUM_DEV-1:0]      dev_resp_i,
  input  logic [l2e_pkg::NUM_DEV-1:0]               dev_v_i,
  output logic [l2e_pkg::NUM_DEV-1:0]               dev_ready_o,
  output l2e_pkg::msg_s                             resp_o,
  output logic                                      resp_v_o,
  input  logic                                      resp_ready_i
);

  import l2e_pkg::*;

  logic [$clog2(NUM_DEV)-1:0] last_q;
  logic [$clog2(NUM_DEV)-1:0] gnt_q;
  logic [$clog2(NUM_DEV)-1:0] pick;
  logic [$clog2(NUM_DEV)-1:0] gnt;
  logic                       lock_q;

  // First valid source after the last granted one
  always_comb
  begin
    int unsigned cand;
    logic        found;
    pick  = last_q;
    found = 1'b0;
    for (int k = 1; k <= NUM_DEV; k++)
    begin
      cand = (int'(last_q) + k) % NUM_DEV;
      if (!found && dev_v_i[cand])
      begin
        pick  = cand[$clog2(NUM_DEV)-1:0];
        found = 1'b1;
      end
    end
  end

  assign gnt         = lock_q ? gnt_q : pick;
  assign resp_v_o    = dev_v_i[gnt];
  assign resp_o      = dev_resp_i[gnt];
  assign dev_ready_o = (NUM_DEV'(1) << gnt) & {NUM_DEV{resp_ready_i && resp_v_o}};

  // Grant stays put while the output stalls
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      last_q <= $clog2(NUM_DEV)'(NUM_DEV - 1);
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end
    else
    begin
      gnt_q  <= gnt;
      lock_q <= resp_v_o && !resp_ready_i;
      if (resp_v_o && resp_ready_i)
        last_q <= gnt;
    end
  end

endmodule

`default_nettype wire

//--- rtl/loopback_dev.sv
`timescale 1ns/1ps
`default_nettype none

module loopback_dev (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  l2e_pkg::msg_s  cmd_i,
  input  logic           cmd_v_i,
  output logic           cmd_ready_o,
  output l2e_pkg::msg_s  resp_o,
  output logic           resp_v_o,
  input  logic           resp_ready_i
);

  import l2e_pkg::*;

  msg_header_s hdr_q;
  logic        resp_v_q;
  logic        accept;

  assign cmd_ready_o = !resp_v_q || resp_ready_i;
  assign accept      = cmd_v_i && cmd_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      resp_v_q <= 1'b0;
    else if (accept)
      resp_v_q <= 1'b1;
    else if (resp_ready_i)
      resp_v_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      hdr_q <= cmd_i.header;
  end

  // Header echoed, data always zero
  assign resp_o   = '{header: hdr_q, data: '0};
  assign resp_v_o = resp_v_q;

endmodule

`default_nettype wire

//--- rtl/mem_store.sv
`timescale 1ns/1ps
`default_nettype none

module mem_store (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  l2e_pkg::msg_s  cmd_i,
  input  logic           cmd_v_i,
  output logic           cmd_ready_o,
  output l2e_pkg::msg_s  resp_o,
  output logic           resp_v_o,
  input  logic           resp_ready_i,
  input  logic           freeze_i
);

  import l2e_pkg::*;

  logic [DATA_W-1:0]            mem_q [MEM_DEPTH];
  logic [$clog2(MEM_DEPTH)-1:0] idx;
  logic                         is_write;
  logic                         accept;
  logic [DATA_W-1:0]            rd_data;
  msg_s                         resp_q;
  logic                         resp_v_q;

  // 8-byte words
  assign idx         = cmd_i.header.addr.flat[3 +: $clog2(MEM_DEPTH)];
  assign is_write    = (cmd_i.header.msg_type == MSG_WRITE);
  assign cmd_ready_o = !resp_v_q || resp_ready_i;
  assign accept      = cmd_v_i && cmd_ready_o;

  // Frozen store reads as zero
  assign rd_data = freeze_i ? '0 : mem_q[idx];

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 0; i < MEM_DEPTH; i++)
      begin
        mem_q[i] <= '0;
      end
      resp_v_q <= 1'b0;
    end
    else
    begin
      if (accept && is_write && !freeze_i)
      begin
        mem_q[idx] <= cmd_i.data;
      end
      if (accept)
      begin
        resp_v_q <= 1'b1;
      end
      else if (resp_ready_i)
      begin
        resp_v_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_q.header <= cmd_i.header;
      resp_q.data   <= is_write ? '0 : rd_data;
    end
  end

  assign resp_o   = resp_q;
  assign resp_v_o = resp_v_q;

endmodule

`default_nettype wire

//--- rtl/cfg_slice.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_slice (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  l2e_pkg::msg_s               cmd_i,
  input  logic                        cmd_v_i,
  output logic                        cmd_ready_o,
  output l2e_pkg::msg_s               resp_o,
  output logic                        resp_v_o,
  input  logic                        resp_ready_i,
  input  logic [l2e_pkg::DATA_W-1:0]  tile_id_i,
  output logic                        freeze_o
);

  import l2e_pkg::*;

  logic                freeze_q;
  logic [DATA_W-1:0]   scratch_q;
  logic [DATA_W-1:0]   rd_data;
  logic [OFFSET_W-1:0] offset;
  logic                is_write;
  logic                accept;
  msg_s                resp_q;
  logic                resp_v_q;

  assign offset      = cmd_i.header.addr.split.offset;
  assign is_write    = (cmd_i.header.msg_type == MSG_WRITE);
  assign cmd_ready_o = !resp_v_q || resp_ready_i;
  assign accept      = cmd_v_i && cmd_ready_o;

  always_comb
  begin
    case (offset)
      CFG_FREEZE_OFS:  rd_data = {{(DATA_W-1){1'b0}}, freeze_q};
      CFG_SCRATCH_OFS: rd_data = scratch_q;
      CFG_ID_OFS:      rd_data = tile_id_i;
      default:         rd_data = '0;
    endcase
  end

  // Freeze comes up set
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      freeze_q  <= 1'b1;
      scratch_q <= '0;
      resp_v_q  <= 1'b0;
    end
    else
    begin
      if (accept && is_write && (offset == CFG_FREEZE_OFS))
      begin
        freeze_q <= cmd_i.data[0];
      end
      if (accept && is_write && (offset == CFG_SCRATCH_OFS))
      begin
        scratch_q <= cmd_i.data;
      end
      if (accept)
      begin
        resp_v_q <= 1'b1;
      end
      else if (resp_ready_i)
      begin
        resp_v_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_q.header <= cmd_i.header;
      resp_q.data   <= is_write ? '0 : rd_data;
    end
  end

  assign resp_o   = resp_q;
  assign resp_v_o = resp_v_q;
  assign freeze_o = freeze_q;

endmodule

`default_nettype wire

//--- rtl/cmd_router.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_router (
  input  l2e_pkg::msg_s                   cmd_i,
  input  logic                            cmd_v_i,
  output logic                            cmd_ready_o,
  output l2e_pkg::msg_s                   dev_cmd_o,
  output logic [l2e_pkg::NUM_DEV-1:0]     dev_v_o,
  input  logic [l2e_pkg::NUM_DEV-1:0]     dev_ready_i
);

  import l2e_pkg::*;

  addr_u              addr;
  logic               is_dram;
  logic [NUM_DEV-1:0] dev_sel;

  assign addr    = cmd_i.header.addr;
  assign is_dram = (addr.flat >= DRAM_BASE);

  // One-hot device select
  always_comb
  begin
    dev_sel = '0;
    if (is_dram || (addr.split.dev == DEV_MEM))
    begin
      dev_sel[DEV_IDX_MEM] = 1'b1;
    end
    else if (addr.split.dev == DEV_CFG)
    begin
      dev_sel[DEV_IDX_CFG] = 1'b1;
    end
    else
    begin
      dev_sel[DEV_IDX_LOOP] = 1'b1;
    end
  end

  // Payload fans out, only the chosen valid rises
  assign dev_cmd_o   = cmd_i;
  assign dev_v_o     = dev_sel & {NUM_DEV{cmd_v_i}};
  assign cmd_ready_o = |(dev_sel & dev_ready_i);

endmodule

`default_nettype wire

//--- rtl/l2e_pkg.sv
`default_nettype none

package l2e_pkg;

  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 64;
  localparam int TAG_W     = 4;
  localparam int DEV_W     = 4;
  localparam int OFFSET_W  = 20;
  localparam int NUM_DEV   = 3;
  localparam int MEM_DEPTH = 16;

  // Address map
  localparam logic [ADDR_W-1:0] DRAM_BASE = 32'h8000_0000;
  localparam logic [DEV_W-1:0]  DEV_CFG   = 4'd1;
  localparam logic [DEV_W-1:0]  DEV_MEM   = 4'd2;

  // Configuration register offsets
  localparam logic [OFFSET_W-1:0] CFG_FREEZE_OFS  = 20'h0;
  localparam logic [OFFSET_W-1:0] CFG_SCRATCH_OFS = 20'h8;
  localparam logic [OFFSET_W-1:0] CFG_ID_OFS      = 20'h10;

  // Slots in the router and merge vectors
  localparam int DEV_IDX_MEM  = 0;
  localparam int DEV_IDX_CFG  = 1;
  localparam int DEV_IDX_LOOP = 2;

  typedef enum logic [0:0] {
    MSG_READ  = 1'b0,
    MSG_WRITE = 1'b1
  } msg_type_e;

  typedef struct packed {
    logic [7:0]          unused;
    logic [DEV_W-1:0]    dev;
    logic [OFFSET_W-1:0] offset;
  } local_addr_s;

  // Same word, seen flat or as device/offset
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    local_addr_s       split;
  } addr_u;

  typedef struct packed {
    msg_type_e          msg_type;
    addr_u              addr;
    logic [TAG_W-1:0]   tag;
  } msg_header_s;

  typedef struct packed {
    msg_header_s       header;
    logic [DATA_W-1:0] data;
  } msg_s;

endpackage

`default_nettype wire
